/* logic/scratch_pkg.sv */
// scratch_pkg: widths, config-space constants and shared types for the scratchpad slave
package scratch_pkg;

  // ============================================================
  // bus and memory geometry
  // ============================================================
  localparam int DATA_BYTES = 32;         // byte lanes per bus word
  localparam int RAM_ROWS   = 128;        // 4 KiB of 32-byte rows
  localparam int RD_LATENCY = 3;          // edges from request sample to response

  typedef logic [8*DATA_BYTES-1:0] data_t; // 256-bit bus data word
  typedef logic [DATA_BYTES-1:0]   sel_t;  // one bit per byte lane
  typedef logic [31:0]             addr_t; // byte address
  typedef logic [7:0]              tid_t;  // transaction id
  typedef logic [6:0]              row_t;  // ram row, adr[11:5]
  typedef logic [3:0]              cfg_row_t; // header row, adr[7:5] zero extended

  // ============================================================
  // config decode and base address register
  // ============================================================
  localparam logic [7:0] CFG_BUS    = 8'd0;   // vs adr[27:20]
  localparam logic [4:0] CFG_DEVICE = 5'd11;  // vs adr[19:15]
  localparam logic [2:0] CFG_FUNC   = 3'd0;   // vs adr[14:12]

  localparam addr_t BAR0_RESET = 32'hFFF0_0001; // window at top of map, 1 MiB
  localparam addr_t BAR0_MASK  = 32'hFFF0_0000; // compared and writable bits

  // ============================================================
  // identity header contents
  // ============================================================
  localparam logic [15:0] CFG_VENDOR_ID       = 16'h0000;
  localparam logic [15:0] CFG_DEVICE_ID       = 16'h0000;
  localparam logic [7:0]  CFG_CLASS           = 8'h05;  // memory controller
  localparam logic [7:0]  CFG_SUBCLASS        = 8'h00;  // ram
  localparam logic [7:0]  CFG_PROGIF          = 8'h01;
  localparam logic [7:0]  CFG_REVISION_ID     = 8'h00;
  localparam logic [7:0]  CFG_HEADER_TYPE     = 8'h00;  // general device
  localparam logic [7:0]  CFG_CACHE_LINE_SIZE = 8'd8;   // in 32-bit units
  localparam logic [7:0]  CFG_IRQ_LINE        = 8'hFF;  // not wired

  // word index of each field in the 16-word header
  // word 15 sits at byte 0x3c, so the header spans header rows 0 and 1
  localparam int CFG_WORD_ID    = 0;
  localparam int CFG_WORD_CLASS = 2;
  localparam int CFG_WORD_HDR   = 3;
  localparam int CFG_WORD_BAR0  = 4;
  localparam int CFG_WORD_IRQ   = 15;

endpackage

/* logic/req_decode.sv */
// req_decode: stage 1, registers the bus request and decodes config and memory selects
`timescale 1ns/1ps
`default_nettype none

module req_decode (
  input  wire logic                 sys_slave,   // bus clock
  input  wire logic                 arst_n_i,
  input  wire logic                 cs_config_i, // config space cycle
  input  wire logic                 cyc_i,
  input  wire logic                 we_i,
  input  wire logic                 erc_i,       // end of burst, write wants ack
  input  wire scratch_pkg::sel_t    sel_i,
  input  wire scratch_pkg::addr_t   adr_i,
  input  wire scratch_pkg::data_t   dat_i,
  input  wire scratch_pkg::tid_t    tid_i,
  input  wire scratch_pkg::addr_t   bar0_i,      // live bar0 from config_space
  output logic                      cs_config_o,
  output logic                      cs_ram_o,
  output logic                      we_o,
  output scratch_pkg::sel_t         sel_o,
  output scratch_pkg::row_t         row_o,
  output scratch_pkg::cfg_row_t     cfg_word_o,
  output scratch_pkg::data_t        dat_o,
  output scratch_pkg::tid_t         tid_o,
  output scratch_pkg::addr_t        adr_o,
  output logic                      ack_req_o,   // this request gets an ack
  output logic                      cfg_rd_o     // response data comes from header
);
  import scratch_pkg::*;

  logic  cyc_q, we_q, erc_q, cs_cfg_q;
  logic  cfg_hit;  // bus/device/function match on the raw address
  addr_t adr_q;
  logic  bar_hit;

  assign cfg_hit = adr_i[27:20] == CFG_BUS &&
                   adr_i[19:15] == CFG_DEVICE &&
                   adr_i[14:12] == CFG_FUNC;

  // ============================================================
  // stage 1 request register
  // ============================================================
  always_ff @(posedge sys_slave or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cyc_q    <= 1'b0;
      we_q     <= 1'b0;
      erc_q    <= 1'b0;
      cs_cfg_q <= 1'b0;
    end else begin
      cyc_q    <= cyc_i;
      we_q     <= we_i;
      erc_q    <= erc_i;
      cs_cfg_q <= cs_config_i & cyc_i & cfg_hit; // decoded before the edge
    end
  end

  // payload, qualified by the selects downstream
  always_ff @(posedge sys_slave) begin
    sel_o <= sel_i;
    adr_q <= adr_i;
    dat_o <= dat_i;
    tid_o <= tid_i;
  end

  // memory select follows bar0 without a register, so a bar0 write
  // is seen by the very next request
  assign bar_hit  = ((adr_q ^ bar0_i) & BAR0_MASK) == '0;
  assign cs_ram_o = cyc_q & ~cs_cfg_q & bar_hit; // config wins on overlap

  assign cs_config_o = cs_cfg_q;
  assign we_o        = we_q;
  assign adr_o       = adr_q;
  assign row_o       = adr_q[11:5];                // 4 KiB aliases in the window
  assign cfg_word_o  = cfg_row_t'(adr_q[7:5]);     // adr 11..8 ignored

  // reads always ack, writes only at end of burst
  assign ack_req_o = (cs_cfg_q | cs_ram_o) & (~we_q | erc_q);
  assign cfg_rd_o  = cs_cfg_q & ~we_q;

  // a selected request is echoed back so its id and address must be known
  a_sel_known: assert property (@(posedge sys_slave) disable iff (!arst_n_i)
    (cs_config_o || cs_ram_o) |-> !$isunknown({tid_o, adr_o}))
    else $error("selected request with unknown tid or adr");

endmodule

`default_nettype wire

/* logic/config_space.sv */
// config_space: identity header with writable bar0, read data aligned to ram latency
`timescale 1ns/1ps
`default_nettype none

module config_space (
  input  wire logic                 sys_slave,
  input  wire logic                 arst_n_i,
  input  wire logic                 cs_config_i, // stage-1 config select
  input  wire logic                 we_i,
  input  wire scratch_pkg::sel_t    sel_i,
  input  wire scratch_pkg::cfg_row_t row_i,      // header row
  input  wire scratch_pkg::data_t   dat_i,
  output scratch_pkg::addr_t        bar0_o,
  output scratch_pkg::data_t        rdat_o       // valid two edges after select
);
  import scratch_pkg::*;

  addr_t bar0_q;
  logic  [31:0] hdr_word [16]; // full 64-byte header, word per entry
  data_t hdr_row;              // selected header row
  logic  bar0_wr;
  data_t rd1_q, rd2_q;         // read pipe, matches ram address + output regs

  // ============================================================
  // header image
  // ============================================================
  always_comb begin
    for (int w = 0; w < 16; w++) begin
      hdr_word[w] = '0;                          // reserved words read zero
    end
    hdr_word[CFG_WORD_ID]    = {CFG_DEVICE_ID, CFG_VENDOR_ID};
    hdr_word[CFG_WORD_CLASS] = {CFG_CLASS, CFG_SUBCLASS, CFG_PROGIF, CFG_REVISION_ID};
    hdr_word[CFG_WORD_HDR]   = {8'h00, CFG_HEADER_TYPE, 8'h00, CFG_CACHE_LINE_SIZE};
    hdr_word[CFG_WORD_BAR0]  = bar0_q;
    hdr_word[CFG_WORD_IRQ]   = {24'h0, CFG_IRQ_LINE};  // pin and grant fields zero
  end

  // eight words per 32-byte row, rows past 1 are empty
  always_comb begin
    hdr_row = '0;
    if (row_i < 4'd2) begin
      for (int w = 0; w < 8; w++) begin
        hdr_row[32*w +: 32] = hdr_word[8*row_i + w];
      end
    end
  end

  // ============================================================
  // bar0
  // ============================================================
  // whole-word write to word 4 of row 0 only
  assign bar0_wr = cs_config_i && we_i && row_i == '0 &&
                   sel_i[4*CFG_WORD_BAR0 +: 4] == 4'hF;

  always_ff @(posedge sys_slave or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bar0_q <= BAR0_RESET;
    end else if (bar0_wr) begin
      bar0_q <= (bar0_q & ~BAR0_MASK) |
                (dat_i[32*CFG_WORD_BAR0 +: 32] & BAR0_MASK); // low bits fixed
    end
  end

  assign bar0_o = bar0_q;

  // ============================================================
  // read path, two registers deep
  // ============================================================
  always_ff @(posedge sys_slave) begin
    if (cs_config_i && !we_i) begin
      rd1_q <= hdr_row;      // bar0 sampled before a same-edge write lands
    end
    rd2_q <= rd1_q;
  end

  assign rdat_o = rd2_q;

  // an unknown bar0 bit would poison every memory decode
  a_bar0_known: assert property (@(posedge sys_slave) disable iff (!arst_n_i)
    !$isunknown(bar0_q))
    else $error("bar0 holds unknown bits");

endmodule

`default_nettype wire

/* logic/scratch_ram.sv */
// scratch_ram: 4 KiB byte-lane writable ram, read-first, two-cycle registered read
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
  input  wire logic                 sys_slave,
  input  wire logic                 en_i,   // memory select from stage 1
  input  wire logic                 we_i,
  input  wire scratch_pkg::sel_t    sel_i,  // per-lane write enable
  input  wire scratch_pkg::row_t    row_i,
  input  wire scratch_pkg::data_t   dat_i,
  output scratch_pkg::data_t        rdat_o  // two edges after en_i
);
  import scratch_pkg::*;

  // ============================================================
  // storage
  // ============================================================
  logic [DATA_BYTES-1:0][7:0] mem [RAM_ROWS]; // contents undefined until written

  row_t  addr_q;  // read address register
  data_t rd_q;    // output register

  // lane writes on the edge after the select
  always_ff @(posedge sys_slave) begin
    for (int b = 0; b < DATA_BYTES; b++) begin
      if (en_i && we_i && sel_i[b]) begin
        mem[row_i][b] <= dat_i[8*b +: 8];
      end
    end
  end

  // ============================================================
  // read pipe
  // ============================================================
  always_ff @(posedge sys_slave) begin
    if (en_i) begin
      addr_q <= row_i;     // hold last address while idle
    end
  end

  // array read happens one edge after the address is taken, so a write
  // landing on this same edge returns the old row
  always_ff @(posedge sys_slave) begin
    rd_q <= mem[addr_q];
  end

  assign rdat_o = rd_q;

endmodule

`default_nettype wire

/* logic/resp_stage.sv */
// resp_stage: delays ack, tid and adr to the ram latency and registers the bus response
`timescale 1ns/1ps
`default_nettype none

module resp_stage (
  input  wire logic                 sys_slave,
  input  wire logic                 arst_n_i,
  input  wire logic                 ack_req_i,  // stage-1 ack eligibility
  input  wire logic                 cfg_rd_i,   // stage-1 config read
  input  wire scratch_pkg::tid_t    tid_i,
  input  wire scratch_pkg::addr_t   adr_i,
  input  wire scratch_pkg::data_t   ram_dat_i,  // already two edges behind stage 1
  input  wire scratch_pkg::data_t   cfg_dat_i,  // same alignment as ram data
  output logic                      ack_o,      // one-cycle pulse
  output scratch_pkg::data_t        dat_o,
  output scratch_pkg::tid_t         tid_o,
  output scratch_pkg::addr_t        adr_o
);
  import scratch_pkg::*;

  localparam int DLY = RD_LATENCY - 1; // stages before the output register

  logic  [DLY-1:0] ack_dly;   // index 0 newest
  logic  [DLY-1:0] cfg_dly;
  tid_t  tid_dly [DLY];
  addr_t adr_dly [DLY];

  // ============================================================
  // delay line
  // ============================================================
  always_ff @(posedge sys_slave or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_dly <= '0;
      cfg_dly <= '0;
    end else begin
      ack_dly <= {ack_dly[DLY-2:0], ack_req_i}; // shift in newest
      cfg_dly <= {cfg_dly[DLY-2:0], cfg_rd_i};
    end
  end

  // tid and adr ride along without reset, ack qualifies them
  always_ff @(posedge sys_slave) begin
    tid_dly[0] <= tid_i;
    adr_dly[0] <= adr_i;
    for (int i = 1; i < DLY; i++) begin
      tid_dly[i] <= tid_dly[i-1];
      adr_dly[i] <= adr_dly[i-1];
    end
  end

  // ============================================================
  // bus response register
  // ============================================================
  always_ff @(posedge sys_slave or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= ack_dly[DLY-1];
    end
  end

  always_ff @(posedge sys_slave) begin
    dat_o <= cfg_dly[DLY-1] ? cfg_dat_i : ram_dat_i; // header or ram
    tid_o <= tid_dly[DLY-1];
    adr_o <= adr_dly[DLY-1];
  end

  // master samples ack every cycle, it must be a clean level
  a_ack_known: assert property (@(posedge sys_slave) disable iff (!arst_n_i)
    !$isunknown(ack_o))
    else $error("ack_o unknown");

endmodule

`default_nettype wire

/* logic/scratchmem_top.sv */
// scratchmem_top: pipelined scratchpad memory slave with config header on the system bus
`timescale 1ns/1ps
`default_nettype none

module scratchmem_top (
  input  wire logic                 sys_slave,
  input  wire logic                 arst_n_i,
  input  wire logic                 cs_config_i,
  input  wire logic                 cyc_i,
  input  wire logic                 we_i,
  input  wire logic                 erc_i,
  input  wire scratch_pkg::sel_t    sel_i,
  input  wire scratch_pkg::addr_t   adr_i,
  input  wire scratch_pkg::data_t   dat_i,
  input  wire scratch_pkg::tid_t    tid_i,
  output logic                      ack_o,
  output scratch_pkg::data_t        dat_o,
  output scratch_pkg::tid_t         tid_o,
  output scratch_pkg::addr_t        adr_o
);
  import scratch_pkg::*;

  // ============================================================
  // stage 1 request and decode
  // ============================================================
  logic     cs_config, cs_ram, we_s1, ack_req, cfg_rd;
  sel_t     sel_s1;
  row_t     row_s1;
  cfg_row_t cfg_row_s1;
  data_t    dat_s1, ram_rdat, cfg_rdat;
  tid_t     tid_s1;
  addr_t    adr_s1, bar0;

  req_decode req_decode_i (
    .sys_slave   (sys_slave),
    .arst_n_i    (arst_n_i),
    .cs_config_i (cs_config_i),
    .cyc_i       (cyc_i),
    .we_i        (we_i),
    .erc_i       (erc_i),
    .sel_i       (sel_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .tid_i       (tid_i),
    .bar0_i      (bar0),        // loops back from config_space
    .cs_config_o (cs_config),
    .cs_ram_o    (cs_ram),
    .we_o        (we_s1),
    .sel_o       (sel_s1),
    .row_o       (row_s1),
    .cfg_word_o  (cfg_row_s1),
    .dat_o       (dat_s1),
    .tid_o       (tid_s1),
    .adr_o       (adr_s1),
    .ack_req_o   (ack_req),
    .cfg_rd_o    (cfg_rd)
  );

  config_space config_space_i (
    .sys_slave   (sys_slave),
    .arst_n_i    (arst_n_i),
    .cs_config_i (cs_config),
    .we_i        (we_s1),
    .sel_i       (sel_s1),
    .row_i       (cfg_row_s1),
    .dat_i       (dat_s1),
    .bar0_o      (bar0),
    .rdat_o      (cfg_rdat)
  );

  scratch_ram scratch_ram_i (
    .sys_slave (sys_slave),
    .en_i      (cs_ram),
    .we_i      (we_s1),
    .sel_i     (sel_s1),
    .row_i     (row_s1),
    .dat_i     (dat_s1),
    .rdat_o    (ram_rdat)
  );

  // ============================================================
  // response
  // ============================================================
  resp_stage resp_stage_i (
    .sys_slave (sys_slave),
    .arst_n_i  (arst_n_i),
    .ack_req_i (ack_req),
    .cfg_rd_i  (cfg_rd),
    .tid_i     (tid_s1),
    .adr_i     (adr_s1),
    .ram_dat_i (ram_rdat),
    .cfg_dat_i (cfg_rdat),
    .ack_o     (ack_o),
    .dat_o     (dat_o),
    .tid_o     (tid_o),
    .adr_o     (adr_o)
  );

endmodule

`default_nettype wire

/* bench/scratch_checker.sv */
// scratch_checker: pairs every bus ack with the expected response queue and counts errors
`timescale 1ns/1ps
`default_nettype none

module scratch_checker (
  input  wire logic               sys_slave,
  input  wire logic               arst_n_i,
  input  wire logic               ack_i,        // dut response
  input  wire scratch_pkg::data_t dat_i,
  input  wire scratch_pkg::tid_t  tid_i,
  input  wire scratch_pkg::addr_t adr_i,
  input  wire logic               exp_valid_i,  // request on this edge must be acked
  input  wire logic               exp_rd_i,     // data is compared only for reads
  input  wire scratch_pkg::tid_t  exp_tid_i,
  input  wire scratch_pkg::addr_t exp_adr_i,
  input  wire scratch_pkg::data_t exp_dat_i,
  output int                      mismatch_cnt_o,
  output int                      fault_cnt_o,
  output int                      ack_cnt_o,
  output int                      pending_o     // responses still outstanding
);
  import scratch_pkg::*;

  int    edge_cnt = 0;  // rising edges seen so far
  int    mismatches = 0;
  int    faults = 0;
  int    acks = 0;
  int    pending = 0;
  int    due_q [$];     // edge after which the ack must show
  logic  rd_q  [$];
  tid_t  tid_q [$];
  addr_t adr_q [$];
  data_t dat_q [$];

  assign mismatch_cnt_o = mismatches;
  assign fault_cnt_o    = faults;
  assign ack_cnt_o      = acks;
  assign pending_o      = pending;

  task automatic drop_head();
    void'(due_q.pop_front());
    void'(rd_q.pop_front());
    void'(tid_q.pop_front());
    void'(adr_q.pop_front());
    void'(dat_q.pop_front());
  endtask

  // ============================================================
  // expectations in on the rising edge, outputs checked mid-cycle
  // ============================================================
  always @(sys_slave) begin
    if (sys_slave) begin
      edge_cnt = edge_cnt + 1;
      if (arst_n_i && exp_valid_i) begin
        due_q.push_back(edge_cnt + RD_LATENCY); // fixed latency from request edge
        rd_q.push_back(exp_rd_i);
        tid_q.push_back(exp_tid_i);
        adr_q.push_back(exp_adr_i);
        dat_q.push_back(exp_dat_i);
      end
    end else if (arst_n_i) begin
      if ($isunknown(ack_i)) begin
        faults++;
        $display("[%0t] ack_o is unknown after reset", $time);
      end else if (ack_i) begin
        acks++;
        if (due_q.size() == 0) begin
          faults++;
          $display("[%0t] ack_o high with no request outstanding, tid_o %h", $time, tid_i);
        end else begin
          if (due_q[0] != edge_cnt) begin
            faults++;
            $display("[%0t] response for tid %h came after edge %0d instead of edge %0d",
                     $time, tid_q[0], edge_cnt, due_q[0]);
          end
          if (tid_i !== tid_q[0]) begin
            mismatches++;
            $display("MISMATCH tid_o at %0t: got %h, expected %h", $time, tid_i, tid_q[0]);
          end
          if (adr_i !== adr_q[0]) begin
            mismatches++;
            $display("MISMATCH adr_o at %0t: got %h, expected %h", $time, adr_i, adr_q[0]);
          end
          if (rd_q[0] && dat_i !== dat_q[0]) begin  // writes carry no data back
            mismatches++;
            $display("MISMATCH dat_o at %0t (tid %h): got %h, expected %h",
                     $time, tid_q[0], dat_i, dat_q[0]);
          end
          drop_head();
        end
      end else if (due_q.size() != 0 && due_q[0] <= edge_cnt) begin
        faults++;
        $display("[%0t] no ack for tid %h, it was due after edge %0d",
                 $time, tid_q[0], due_q[0]);
        drop_head();
      end
    end
    pending = due_q.size();
  end

endmodule

`default_nettype wire

/* bench/tb_scratchmem.sv */
// tb_scratchmem: random and directed bus traffic for the scratchpad slave against a model
`timescale 1ns/1ps
`default_nettype none

module tb_scratchmem;
  import scratch_pkg::*;

  localparam int   DRAIN_LIMIT = 40;        // cycles allowed for outstanding acks
  localparam addr_t NEW_BAR    = 32'h4567_89AB;

  logic  sys_slave, arst_n_i, cs_config_i, cyc_i, we_i, erc_i, ack_o;
  sel_t  sel_i;
  addr_t adr_i, adr_o;
  data_t dat_i, dat_o;
  tid_t  tid_i, tid_o;
  logic  exp_valid, exp_rd;                  // expectation travels with the request
  data_t exp_dat;
  int    mismatches, faults, acks, pending, timeouts;

  logic [DATA_BYTES-1:0][7:0] ram_model [RAM_ROWS];  // byte image of the ram
  addr_t bar0_model;
  tid_t  next_tid;

  scratchmem_top scratchmem_top_i (
    .sys_slave, .arst_n_i, .cs_config_i, .cyc_i, .we_i, .erc_i,
    .sel_i, .adr_i, .dat_i, .tid_i, .ack_o, .dat_o, .tid_o, .adr_o
  );

  scratch_checker scratch_checker_i (
    .sys_slave, .arst_n_i, .ack_i(ack_o), .dat_i(dat_o), .tid_i(tid_o), .adr_i(adr_o),
    .exp_valid_i(exp_valid), .exp_rd_i(exp_rd), .exp_tid_i(tid_i), .exp_adr_i(adr_i),
    .exp_dat_i(exp_dat), .mismatch_cnt_o(mismatches), .fault_cnt_o(faults),
    .ack_cnt_o(acks), .pending_o(pending)
  );

  initial begin
    sys_slave = 1'b0;
    forever #20 sys_slave = ~sys_slave;  // 40 ns period
  end

  function automatic data_t rand_data();
    data_t d;
    for (int i = 0; i < 8; i++) d[32*i +: 32] = $urandom;
    return d;
  endfunction

  // 64-byte identity header, rows 0 and 1 of config space
  function automatic data_t header_row(input logic [2:0] hrow);
    logic [31:0] w [16];
    data_t r;
    for (int i = 0; i < 16; i++) w[i] = '0;
    w[0]  = {CFG_DEVICE_ID, CFG_VENDOR_ID};
    w[2]  = {CFG_CLASS, CFG_SUBCLASS, CFG_PROGIF, CFG_REVISION_ID};
    w[3]  = {8'h00, CFG_HEADER_TYPE, 8'h00, CFG_CACHE_LINE_SIZE};
    w[4]  = bar0_model;
    w[15] = {24'h0, CFG_IRQ_LINE};
    r = '0;
    if (hrow < 3'd2) for (int i = 0; i < 8; i++) r[32*i +: 32] = w[8*hrow + i];
    return r;
  endfunction

  function automatic addr_t ram_addr(input row_t row);
    return {bar0_model[31:20], 8'($urandom), row, 5'($urandom)};  // aliases inside window
  endfunction

  function automatic addr_t cfg_addr(input logic [2:0] hrow);
    return {4'($urandom), CFG_BUS, CFG_DEVICE, CFG_FUNC, 4'($urandom), hrow, 5'h0};
  endfunction

  function automatic addr_t stray_addr();
    addr_t a;
    a = $urandom;
    if (((a ^ bar0_model) & BAR0_MASK) == '0) a[31:20] = ~bar0_model[31:20];
    return a;
  endfunction

  // ============================================================
  // reference model, one request at a time in bus order
  // ============================================================
  task automatic model_req(input logic cfg_sel, input logic we, input logic erc,
                           input sel_t sel, input addr_t adr, input data_t dat,
                           output logic ack, output logic rd, output data_t edat);
    logic cfg_hit, ram_hit;
    row_t row;
    cfg_hit = cfg_sel && adr[27:20] == CFG_BUS && adr[19:15] == CFG_DEVICE &&
              adr[14:12] == CFG_FUNC;
    ram_hit = !cfg_hit && ((adr ^ bar0_model) & BAR0_MASK) == '0;  // config wins
    row  = adr[11:5];
    rd   = !we;
    edat = '0;
    if (cfg_hit && !we) edat = header_row(adr[7:5]);
    if (cfg_hit && we && adr[7:5] == 3'd0 && sel[19:16] == 4'hF)
      bar0_model = (bar0_model & ~BAR0_MASK) | (dat[159:128] & BAR0_MASK);
    if (ram_hit && !we) edat = ram_model[row];
    if (ram_hit && we)
      for (int b = 0; b < DATA_BYTES; b++) if (sel[b]) ram_model[row][b] = dat[8*b +: 8];
    ack = (cfg_hit || ram_hit) && (!we || erc);  // writes ack only at end of burst
  endtask

  task automatic drive_req(input logic cfg_sel, input logic we, input logic erc,
                           input sel_t sel, input addr_t adr, input data_t dat);
    logic ack, rd;
    data_t edat;
    model_req(cfg_sel, we, erc, sel, adr, dat, ack, rd, edat);
    @(negedge sys_slave);
    cs_config_i = cfg_sel;
    cyc_i       = 1'b1;
    we_i        = we;
    erc_i       = erc;
    sel_i       = sel;
    adr_i       = adr;
    dat_i       = dat;
    tid_i       = next_tid;
    exp_valid   = ack;
    exp_rd      = rd;
    exp_dat     = edat;
    next_tid    = next_tid + 8'd1;
  endtask

  task automatic drive_idle();
    @(negedge sys_slave);
    cyc_i       = 1'b0;
    cs_config_i = 1'($urandom);  // junk while cyc is low
    we_i        = 1'($urandom);
    adr_i       = $urandom;
    exp_valid   = 1'b0;
  endtask

  task automatic random_traffic(input int n);
    int   kind;
    row_t row;
    for (int i = 0; i < n; i++) begin
      kind = $urandom_range(0, 99);
      row  = 7'($urandom);
      if (kind < 60) begin
        drive_req(1'b0, 1'($urandom), 1'($urandom), $urandom, ram_addr(row), rand_data());
      end else if (kind < 70) begin  // read straight after a write to the same row
        drive_req(1'b0, 1'b1, 1'($urandom), $urandom, ram_addr(row), rand_data());
        drive_req(1'b0, 1'b0, 1'b0, '0, ram_addr(row), rand_data());
      end else if (kind < 80) begin
        drive_req(1'b1, 1'b0, 1'b0, '0, cfg_addr(3'($urandom)), rand_data());
      end else if (kind < 90) begin
        drive_req(1'($urandom), 1'($urandom), 1'($urandom), $urandom, stray_addr(),
                  rand_data());
      end else begin
        drive_idle();
      end
    end
  endtask

  // ============================================================
  // test sequence
  // ============================================================
  initial begin
    data_t fill;
    row_t  burst [8];
    int    ba;
    int    wait_cnt;
    void'($urandom(32'hed01));
    {cs_config_i, cyc_i, we_i, erc_i} = '0;
    sel_i = '0;
    adr_i = '0;
    dat_i = '0;
    tid_i = '0;
    {exp_valid, exp_rd} = '0;
    exp_dat    = '0;
    bar0_model = BAR0_RESET;
    next_tid   = '0;
    timeouts   = 0;
    arst_n_i   = 1'b0;
    repeat (8) @(posedge sys_slave);
    @(negedge sys_slave);
    arst_n_i = 1'b1;

    for (int r = 0; r < RAM_ROWS; r++) begin  // preload, value set by byte address
      for (int b = 0; b < DATA_BYTES; b++) begin
        ba = r * DATA_BYTES + b;
        fill[8*b +: 8] = 8'((ba * 13) ^ (ba >> 4));
      end
      drive_req(1'b0, 1'b1, 1'b1, '1, ram_addr(7'(r)), fill);
    end

    for (int i = 0; i < 8; i++) burst[i] = 7'($urandom);
    for (int i = 0; i < 8; i++) drive_req(1'b0, 1'b1, 1'b1, $urandom, ram_addr(burst[i]),
                                          rand_data());  // lane merge
    for (int i = 0; i < 8; i++) drive_req(1'b0, 1'b0, 1'b0, '0, ram_addr(burst[i]), '0);
    for (int i = 0; i < 8; i++) drive_req(1'b0, 1'b1, 1'b0, $urandom, ram_addr(burst[i]),
                                          rand_data());  // silent writes
    for (int i = 0; i < 8; i++) drive_req(1'b0, 1'b0, 1'b0, '0, ram_addr(burst[i]), '0);
    for (int i = 0; i < 4; i++) drive_req(1'($urandom), 1'b0, 1'b0, '0, stray_addr(), '0);

    for (int h = 0; h < 8; h++) drive_req(1'b1, 1'b0, 1'b0, '0, cfg_addr(3'(h)), '0);
    drive_req(1'b0, 1'b0, 1'b0, '0, cfg_addr(3'd0), '0);  // cs_config low, no bar hit

    fill = '0;
    fill[159:128] = NEW_BAR;
    drive_req(1'b1, 1'b1, 1'b1, 32'h0007_0000, cfg_addr(3'd0), fill);  // partial, ignored
    drive_req(1'b1, 1'b1, 1'b1, 32'h000F_0000, cfg_addr(3'd0), fill);  // relocate bar0
    drive_req(1'b1, 1'b0, 1'b0, '0, cfg_addr(3'd0), '0);
    for (int i = 0; i < 8; i++)
      drive_req(1'b0, 1'b0, 1'b0, '0, {12'hFFF, 8'($urandom), burst[i], 5'h0}, '0);
    for (int i = 0; i < 8; i++) drive_req(1'b0, 1'b0, 1'b0, '0, ram_addr(burst[i]), '0);

    random_traffic(400);
    drive_idle();

    wait_cnt = 0;
    while (pending != 0 && wait_cnt < DRAIN_LIMIT) begin
      @(posedge sys_slave);
      wait_cnt++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("timeout: %0d responses never arrived", pending);
    end
    repeat (RD_LATENCY + 2) @(posedge sys_slave);  // catch stray acks

    $display("errors: %0d mismatches, %0d protocol faults, %0d timeouts, %0d acks checked",
             mismatches, faults, timeouts, acks);
    if (mismatches == 0 && faults == 0 && timeouts == 0 && acks > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
logic/scratch_pkg.sv
logic/req_decode.sv
logic/config_space.sv
logic/scratch_ram.sv
logic/resp_stage.sv
logic/scratchmem_top.sv
bench/scratch_checker.sv
bench/tb_scratchmem.sv

/* run_sim.sh */
#!/bin/sh
# build the scratchpad testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_scratchmem -f sources.f > build.log 2>&1 \
  && ./obj_dir/Vtb_scratchmem > sim.log 2>&1 \
  || { echo "build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^Test completed successfully$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
